// File: files.f
+incdir+verif
common/cart_load_pkg.sv
rtl/cart_load_ctrl.sv
rtl/rom_header_parse.sv
rtl/cheat_code_assembler.sv
rtl/ram_fill_pattern.sv
rtl/cart_loader.sv
verif/cart_loader_assert.sv
verif/tb_cart_loader.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the cartridge loader testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -f files.f --top-module tb_cart_loader \
	-Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -qF '*** TEST FAILED ***' "$LOG"; then
	echo "Failure reported in $LOG"
	exit 1
fi

echo "No failure reported in $LOG"
exit 0

// File: verif/cart_loader_model.svh
// Reference model of the header, region, cheat and fill rules of the cartridge loader
`ifndef CART_LOADER_MODEL_SVH
`define CART_LOADER_MODEL_SVH

// Address of the ROM size word for a forced header mode
function automatic dl_addr_t size_addr_of(input header_mode_t mode);
	dl_addr_t addr;
	case (mode)
		3'd2:    addr = 25'h7FD6 + 25'h200;
		3'd3:    addr = 25'hFFD6 + 25'h200;
		3'd4:    addr = 25'h40FFD6 + 25'h200;
		default: addr = 25'h0;
	endcase
	return addr;
endfunction

function automatic logic [3:0] rom_size_rule(input header_mode_t mode, input dl_word_t w0,
		input dl_word_t wsz);
	logic [3:0] size;
	size = 4'd12;
	if (mode == 3'd0 && w0[7:0] != 8'h00) begin
		size = w0[3:0];
	end
	if (mode >= 3'd2 && mode <= 3'd4) begin
		size = wsz[11:8];
	end
	return size;
endfunction

function automatic logic [3:0] ram_size_rule(input header_mode_t mode, input dl_word_t w0,
		input dl_word_t wram);
	logic [3:0] size;
	size = 4'd0;
	if (mode == 3'd0 && w0[7:0] != 8'h00) begin
		size = w0[7:4];
	end
	if (mode >= 3'd2 && mode <= 3'd4) begin
		size = wram[3:0];
	end
	return size;
endfunction

// 1 KB units, an empty save RAM has no mask
function automatic mem_mask_t mask_rule(input logic [3:0] size, input logic is_ram);
	mem_mask_t mask;
	mask = (24'd1024 << size) - 24'd1;
	if (is_ram && size == 4'd0) begin
		mask = 24'd0;
	end
	return mask;
endfunction

function automatic rom_type_t type_rule(input header_mode_t mode, input dl_word_t w0);
	rom_type_t t;
	case (mode)
		3'd0:    t = w0[15:8];
		3'd3:    t = 8'd1;
		3'd4:    t = 8'd2;
		default: t = 8'd0;
	endcase
	return t;
endfunction

function automatic logic region_rule(input logic [1:0] rsel, input logic region_bit);
	return (rsel == 2'd0) ? region_bit : rsel[1];
endfunction

function automatic fill_byte_t fill_rule(input logic [1:0] sel, input fill_addr_t addr);
	fill_byte_t b;
	case (sel)
		2'd0:    b = (addr[8] != addr[2]) ? 8'h66 : 8'h99;
		2'd1:    b = (addr[9] != addr[0]) ? 8'hFF : 8'h00;
		2'd2:    b = 8'h55;
		default: b = 8'hFF;
	endcase
	return b;
endfunction

`endif

// File: verif/tb_cart_loader.sv
// Cartridge loader testbench with random downloads checked against a reference model
`timescale 1ns/1ps

module tb_cart_loader import cart_load_pkg::*; ();

	logic         clk_sys = 1'b0;
	logic         RESET;
	logic         ioctl_download;
	dl_index_t    ioctl_index;
	dl_addr_t     ioctl_addr;
	dl_word_t     ioctl_dout;
	logic         ioctl_wr;
	header_mode_t header_mode;
	logic [1:0]   region_sel;
	logic [1:0]   wram_init_sel;
	logic [1:0]   aram_init_sel;
	rom_type_t    rom_type;
	mem_mask_t    rom_mask;
	mem_mask_t    ram_mask;
	logic         pal;
	cheat_word_t  cheat_flags;
	cheat_word_t  cheat_addr;
	cheat_word_t  cheat_compare;
	cheat_word_t  cheat_replace;
	logic         cheat_valid;
	logic         cheat_reset;
	logic         fill_wr;
	fill_addr_t   fill_addr;
	fill_byte_t   wram_fill;
	fill_byte_t   aram_fill;
	logic         clearing;
	logic         cart_busy;

	logic [31:0] rng;
	logic        busy_all;
	int          err_cnt;
	int          check_cnt;
	int          test_cnt;
	int          fail_cnt;
	int          test_err0;

	`include "cart_loader_model.svh"

	cart_loader i_cart_loader (.*);

	bind cart_load_ctrl cart_loader_assert i_assert (
		.clk_sys    (clk_sys),
		.RESET      (RESET),
		.cart_start (cart_start),
		.clearing   (clearing),
		.sweep_addr (sweep_addr),
		.hdr_wr     (hdr_wr),
		.code_wr    (code_wr)
	);

	initial begin
		forever #5 clk_sys = ~clk_sys;
	end

	// ========================================
	// Helpers
	// ========================================
	function automatic logic [31:0] rand32();
		rng = rng ^ (rng << 13);
		rng = rng ^ (rng >> 17);
		rng = rng ^ (rng << 5);
		return rng;
	endfunction

	task automatic check_value(input string what, input logic [63:0] got,
			input logic [63:0] exp);
		check_cnt++;
		if (got !== exp) begin
			err_cnt++;
			$display("ERR @%0t: %s got %0h expected %0h", $time, what, got, exp);
		end
	endtask

	task automatic end_test(input string name);
		test_cnt++;
		if (err_cnt == test_err0) begin
			$display("test %s finished ok", name);
		end else begin
			fail_cnt++;
			$display("test %s finished with %0d errors", name, err_cnt - test_err0);
		end
		test_err0 = err_cnt;
	endtask

	// One write strobe followed by an idle cycle
	task automatic write_word(input dl_addr_t addr, input dl_word_t data);
		@(negedge clk_sys);
		busy_all   = busy_all & cart_busy;
		ioctl_wr   = 1'b1;
		ioctl_addr = addr;
		ioctl_dout = data;
		@(negedge clk_sys);
		busy_all = busy_all & cart_busy;
		ioctl_wr = 1'b0;
	endtask

	task automatic wait_idle();
		int i;
		for (i = 0; i < 140000 && (clearing || fill_wr); i++) begin
			@(negedge clk_sys);
		end
		if (clearing || fill_wr) begin
			err_cnt++;
			$display("Timeout while waiting for the memory clear to finish");
		end
	endtask

	// ========================================
	// Cartridge download with header words
	// ========================================
	task automatic header_test(input header_mode_t mode, input logic [1:0] rsel);
		logic [31:0] r;
		dl_word_t    w0;
		dl_word_t    w2;
		dl_word_t    wsz;
		dl_word_t    wram;
		dl_addr_t    saddr;
		logic [3:0]  rs;
		logic [3:0]  as;
		int          i;
		r = rand32();
		w0 = r[15:0];
		w2 = r[31:16];
		r = rand32();
		wsz = r[15:0];
		wram = r[31:16];
		r = rand32();
		// Zero size byte now and then selects the default sizes
		if (r[1:0] == 2'd0) begin
			w0[7:0] = 8'h00;
		end
		saddr = size_addr_of(mode);
		@(negedge clk_sys);
		header_mode    = mode;
		region_sel     = rsel;
		ioctl_index    = {r[7:6], 6'b0};
		ioctl_download = 1'b1;
		busy_all       = 1'b1;
		write_word(25'h0, w0);
		for (i = 0; i < int'(r[11:8]); i++) begin
			write_word(dl_addr_t'(4 + 2 * r[24:16] + 2 * i), dl_word_t'(rand32()));
		end
		write_word(25'h2, w2);
		if (mode >= 3'd2 && mode <= 3'd4) begin
			write_word(saddr, wsz);
			write_word(saddr + dl_addr_t'(2), wram);
		end
		write_word(dl_addr_t'(4 + 2 * r[31:25]), dl_word_t'(rand32()));
		ioctl_download = 1'b0;
		repeat (2) @(negedge clk_sys);
		rs = rom_size_rule(mode, w0, wsz);
		as = ram_size_rule(mode, w0, wram);
		check_value("cart_busy during download", 64'(busy_all), 64'd1);
		check_value("rom_type", 64'(rom_type), 64'(type_rule(mode, w0)));
		check_value("rom_mask", 64'(rom_mask), 64'(mask_rule(rs, 1'b0)));
		check_value("ram_mask", 64'(ram_mask), 64'(mask_rule(as, 1'b1)));
		check_value("pal", 64'(pal), 64'(region_rule(rsel, w2[8])));
	endtask

	// ========================================
	// Cheat records in random word order
	// ========================================
	task automatic cheat_test();
		logic [31:0] r;
		dl_word_t    words[8];
		int          order[8];
		int          rec;
		int          i;
		int          j;
		int          k;
		logic        seen;
		@(negedge clk_sys);
		ioctl_index    = IDX_CHEAT;
		ioctl_download = 1'b1;
		for (rec = 0; rec < 6; rec++) begin
			for (i = 0; i < 8; i++) begin
				r = rand32();
				words[i] = r[15:0];
				order[i] = i;
			end
			// Only the first seven are shuffled so offset 14 stays last
			for (i = 6; i > 0; i--) begin
				r = rand32();
				j = r[7:0] % (i + 1);
				k = order[i];
				order[i] = order[j];
				order[j] = k;
			end
			for (i = 0; i < 8; i++) begin
				k = order[i];
				write_word(dl_addr_t'(rec * 16 + k * 2), words[k]);
				if (rec == 0 && k == 0) begin
					check_value("cheat_reset after address 0", 64'(cheat_reset), 64'd1);
				end
				if (k != 7) begin
					check_value("cheat_valid early", 64'(cheat_valid), 64'd0);
				end
			end
			seen = 1'b0;
			for (i = 0; i < 8 && !seen; i++) begin
				if (cheat_valid) begin
					seen = 1'b1;
				end else begin
					@(negedge clk_sys);
				end
			end
			if (!seen) begin
				err_cnt++;
				$display("Timeout while waiting for cheat_valid of record %0d", rec);
			end
			check_value("cheat_flags", 64'(cheat_flags), 64'({words[1], words[0]}));
			check_value("cheat_addr", 64'(cheat_addr), 64'({words[3], words[2]}));
			check_value("cheat_compare", 64'(cheat_compare), 64'({words[5], words[4]}));
			check_value("cheat_replace", 64'(cheat_replace), 64'({words[7], words[6]}));
		end
		ioctl_download = 1'b0;
	endtask

	// ========================================
	// Memory clear after a cartridge start
	// ========================================
	task automatic clear_test();
		logic [31:0] r;
		int          cnt;
		int          dl_len;
		int          i;
		logic        seen;
		logic        done;
		wait_idle();
		r = rand32();
		@(negedge clk_sys);
		wram_init_sel  = r[1:0];
		aram_init_sel  = r[3:2];
		ioctl_index    = IDX_CART;
		ioctl_download = 1'b1;
		dl_len = 2 + int'(r[7:4]);
		cnt  = 0;
		seen = 1'b0;
		done = 1'b0;
		for (i = 0; i < 140000 && !done; i++) begin
			@(negedge clk_sys);
			if (fill_wr) begin
				check_value("fill_addr", 64'(fill_addr), 64'(fill_addr_t'(cnt)));
				check_value("wram_fill", 64'(wram_fill),
					64'(fill_rule(r[1:0], fill_addr_t'(cnt))));
				check_value("aram_fill", 64'(aram_fill),
					64'(fill_rule(r[3:2], fill_addr_t'(cnt))));
				// Sweep runs one address ahead of the fill output
				check_value("cart_busy in sweep", 64'(cart_busy),
					64'(ioctl_download || cnt != 131071));
				cnt++;
				seen = 1'b1;
			end else if (seen) begin
				done = 1'b1;
				check_value("cart_busy after clear", 64'(cart_busy), 64'd0);
				check_value("clearing after clear", 64'(clearing), 64'd0);
			end else begin
				check_value("cart_busy at start", 64'(cart_busy), 64'd1);
			end
			if (i == dl_len) begin
				ioctl_download = 1'b0;
			end
		end
		if (!done) begin
			err_cnt++;
			$display("Timeout while waiting for fill_wr to fall");
		end
		check_value("fill_wr cycles", 64'(cnt), 64'd131072);
	endtask

	// ========================================
	// Test sequence
	// ========================================
	initial begin
		int          i;
		int          m;
		logic [31:0] r;
		rng            = 32'd68597;
		err_cnt        = 0;
		check_cnt      = 0;
		test_cnt       = 0;
		fail_cnt       = 0;
		test_err0      = 0;
		busy_all       = 1'b1;
		RESET          = 1'b1;
		ioctl_download = 1'b0;
		ioctl_index    = '0;
		ioctl_addr     = '0;
		ioctl_dout     = '0;
		ioctl_wr       = 1'b0;
		header_mode    = '0;
		region_sel     = '0;
		wram_init_sel  = '0;
		aram_init_sel  = '0;
		repeat (5) @(negedge clk_sys);
		RESET = 1'b0;
		@(negedge clk_sys);
		check_value("cheat_valid after reset", 64'(cheat_valid), 64'd0);
		check_value("cheat_reset after reset", 64'(cheat_reset), 64'd0);
		check_value("fill_wr after reset", 64'(fill_wr), 64'd0);
		check_value("clearing after reset", 64'(clearing), 64'd0);
		check_value("cart_busy after reset", 64'(cart_busy), 64'd0);
		end_test("reset");

		for (i = 0; i < 8; i++) begin
			r = rand32();
			header_test(3'd0, r[1:0]);
		end
		end_test("auto header");

		for (m = 1; m <= 4; m++) begin
			for (i = 0; i < 3; i++) begin
				r = rand32();
				header_test(header_mode_t'(m), r[1:0]);
			end
		end
		end_test("forced modes");

		for (m = 0; m < 4; m++) begin
			header_test(3'd0, 2'(m));
		end
		end_test("region");

		cheat_test();
		end_test("cheat records");

		clear_test();
		clear_test();
		end_test("memory clear and busy");

		$display("tests %0d, failed %0d, checks %0d, errors %0d",
			test_cnt, fail_cnt, check_cnt, err_cnt);
		if (err_cnt == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

// File: verif/cart_loader_assert.sv
// Concurrent checks on the clear sequencer and the download write strobes
`timescale 1ns/1ps

module cart_loader_assert import cart_load_pkg::*; (
	input logic       clk_sys,
	input logic       RESET,
	input logic       cart_start,
	input logic       clearing,
	input fill_addr_t sweep_addr,
	input logic       hdr_wr,
	input logic       code_wr
);

	// Sweep ends only at the last address
	a_clear_hold: assert property (@(posedge clk_sys) disable iff (RESET)
		clearing && sweep_addr != FILL_LAST |=> clearing)
		else $error("clearing fell before the sweep reached the last address");

	// One address per cycle unless a new cartridge start restarts the sweep
	a_sweep_step: assert property (@(posedge clk_sys) disable iff (RESET)
		clearing && !cart_start && sweep_addr != FILL_LAST
		|=> sweep_addr == fill_addr_t'($past(sweep_addr) + 17'd1))
		else $error("sweep address did not advance by one");

	a_strobe_excl: assert property (@(posedge clk_sys) disable iff (RESET)
		!(hdr_wr && code_wr))
		else $error("header and cheat write strobes high together");

endmodule

// File: rtl/cart_loader.sv
// Cartridge loading front end with header parse, cheat assembly and memory clear
`timescale 1ns/1ps

module cart_loader import cart_load_pkg::*; (
	input  logic         clk_sys,
	input  logic         RESET,
	input  logic         ioctl_download,
	input  dl_index_t    ioctl_index,
	input  dl_addr_t     ioctl_addr,
	input  dl_word_t     ioctl_dout,
	input  logic         ioctl_wr,
	input  header_mode_t header_mode,
	input  logic [1:0]   region_sel,
	input  logic [1:0]   wram_init_sel,
	input  logic [1:0]   aram_init_sel,
	output rom_type_t    rom_type,
	output mem_mask_t    rom_mask,
	output mem_mask_t    ram_mask,
	output logic         pal,
	output cheat_word_t  cheat_flags,
	output cheat_word_t  cheat_addr,
	output cheat_word_t  cheat_compare,
	output cheat_word_t  cheat_replace,
	output logic         cheat_valid,
	output logic         cheat_reset,
	output logic         fill_wr,
	output fill_addr_t   fill_addr,
	output fill_byte_t   wram_fill,
	output fill_byte_t   aram_fill,
	output logic         clearing,
	output logic         cart_busy
);

	logic       cart_active;
	logic       hdr_wr;
	logic       code_wr;
	logic       sweep_en;
	fill_addr_t sweep_addr;

	// ========================================
	// Control
	// ========================================
	cart_load_ctrl i_ctrl (
		.clk_sys        (clk_sys),
		.RESET          (RESET),
		.ioctl_download (ioctl_download),
		.ioctl_index    (ioctl_index),
		.ioctl_wr       (ioctl_wr),
		.cart_active    (cart_active),
		.hdr_wr         (hdr_wr),
		.code_wr        (code_wr),
		.sweep_en       (sweep_en),
		.sweep_addr     (sweep_addr),
		.clearing       (clearing),
		.cart_busy      (cart_busy)
	);

	// ========================================
	// Datapath
	// ========================================
	rom_header_parse i_header (
		.clk_sys     (clk_sys),
		.RESET       (RESET),
		.cart_active (cart_active),
		.hdr_wr      (hdr_wr),
		.ioctl_addr  (ioctl_addr),
		.ioctl_dout  (ioctl_dout),
		.header_mode (header_mode),
		.region_sel  (region_sel),
		.rom_type    (rom_type),
		.rom_mask    (rom_mask),
		.ram_mask    (ram_mask),
		.pal         (pal)
	);

	cheat_code_assembler i_cheat (
		.clk_sys       (clk_sys),
		.RESET         (RESET),
		.cart_active   (cart_active),
		.code_wr       (code_wr),
		.ioctl_addr    (ioctl_addr),
		.ioctl_dout    (ioctl_dout),
		.cheat_flags   (cheat_flags),
		.cheat_addr    (cheat_addr),
		.cheat_compare (cheat_compare),
		.cheat_replace (cheat_replace),
		.cheat_valid   (cheat_valid),
		.cheat_reset   (cheat_reset)
	);

	ram_fill_pattern i_fill (
		.clk_sys       (clk_sys),
		.RESET         (RESET),
		.sweep_en      (sweep_en),
		.sweep_addr    (sweep_addr),
		.wram_init_sel (wram_init_sel),
		.aram_init_sel (aram_init_sel),
		.fill_wr       (fill_wr),
		.fill_addr     (fill_addr),
		.wram_fill     (wram_fill),
		.aram_fill     (aram_fill)
	);

endmodule

// File: rtl/ram_fill_pattern.sv
// Work RAM and audio RAM fill pattern generator for the clear sweep
`timescale 1ns/1ps

module ram_fill_pattern import cart_load_pkg::*; (
	input  logic       clk_sys,
	input  logic       RESET,
	input  logic       sweep_en,
	input  fill_addr_t sweep_addr,
	input  logic [1:0] wram_init_sel,
	input  logic [1:0] aram_init_sel,
	output logic       fill_wr,
	output fill_addr_t fill_addr,
	output fill_byte_t wram_fill,
	output fill_byte_t aram_fill
);

	// Power-on RAM content of the different console revisions
	function automatic fill_byte_t fill_value(input logic [1:0] sel, input fill_addr_t addr);
		fill_byte_t val;
		case (sel)
			2'd0:    val = (addr[8] ^ addr[2]) ? 8'h66 : 8'h99;
			2'd1:    val = (addr[9] ^ addr[0]) ? 8'hFF : 8'h00;
			2'd2:    val = 8'h55;
			default: val = 8'hFF;
		endcase
		return val;
	endfunction

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			fill_wr <= 1'b0;
		end else begin
			fill_wr <= sweep_en;
		end
	end

	always_ff @(posedge clk_sys) begin
		fill_addr <= sweep_addr;
	end

	// Data follows the registered address
	assign wram_fill = fill_value(wram_init_sel, fill_addr);
	assign aram_fill = fill_value(aram_init_sel, fill_addr);

endmodule

// File: rtl/cheat_code_assembler.sv
// Cheat record assembly from eight 16-bit code words
`timescale 1ns/1ps

module cheat_code_assembler import cart_load_pkg::*; (
	input  logic        clk_sys,
	input  logic        RESET,
	input  logic        cart_active,
	input  logic        code_wr,
	input  dl_addr_t    ioctl_addr,
	input  dl_word_t    ioctl_dout,
	output cheat_word_t cheat_flags,
	output cheat_word_t cheat_addr,
	output cheat_word_t cheat_compare,
	output cheat_word_t cheat_replace,
	output logic        cheat_valid,
	output logic        cheat_reset
);

	// Low half at even word, high half two bytes later
	always_ff @(posedge clk_sys) begin
		if (code_wr) begin
			case (ioctl_addr[3:0])
				4'd0:  cheat_flags[15:0]    <= ioctl_dout;
				4'd2:  cheat_flags[31:16]   <= ioctl_dout;
				4'd4:  cheat_addr[15:0]     <= ioctl_dout;
				4'd6:  cheat_addr[31:16]    <= ioctl_dout;
				4'd8:  cheat_compare[15:0]  <= ioctl_dout;
				4'd10: cheat_compare[31:16] <= ioctl_dout;
				4'd12: cheat_replace[15:0]  <= ioctl_dout;
				4'd14: cheat_replace[31:16] <= ioctl_dout;
				default: ;
			endcase
		end
	end

	// Last word of a record clocks it out
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			cheat_valid <= 1'b0;
			cheat_reset <= 1'b0;
		end else begin
			cheat_valid <= code_wr && (ioctl_addr[3:0] == 4'd14);
			// New code list or new cartridge drops all cheats
			cheat_reset <= (code_wr && ioctl_addr == '0) || cart_active;
		end
	end

endmodule

// File: rtl/rom_header_parse.sv
// ROM header parser producing mapper type, address masks and video region
`timescale 1ns/1ps

module rom_header_parse import cart_load_pkg::*; (
	input  logic         clk_sys,
	input  logic         RESET,
	input  logic         cart_active,
	input  logic         hdr_wr,
	input  dl_addr_t     ioctl_addr,
	input  dl_word_t     ioctl_dout,
	input  header_mode_t header_mode,
	input  logic [1:0]   region_sel,
	output rom_type_t    rom_type,
	output mem_mask_t    rom_mask,
	output mem_mask_t    ram_mask,
	output logic         pal
);

	mem_size_t rom_size;
	mem_size_t ram_size;
	logic      rom_region;
	logic      forced;
	dl_addr_t  size_addr;
	dl_addr_t  ram_size_addr;

	// Size word location for the forced modes
	always_comb begin
		forced    = 1'b1;
		size_addr = '0;
		case (header_mode)
			HM_LOROM:   size_addr = HDR_LO_SIZE;
			HM_HIROM:   size_addr = HDR_HI_SIZE;
			HM_EXHIROM: size_addr = HDR_EX_SIZE;
			default:    forced    = 1'b0;
		endcase
	end

	// RAM size sits right after the ROM size word
	assign ram_size_addr = size_addr + dl_addr_t'(2);

	// ========================================
	// Header capture
	// ========================================
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			rom_size   <= DEFAULT_ROM_SIZE;
			ram_size   <= '0;
			rom_type   <= '0;
			rom_region <= 1'b0;
		end else if (hdr_wr) begin
			if (ioctl_addr == '0) begin
				rom_size <= DEFAULT_ROM_SIZE;
				ram_size <= '0;
				// Sizes packed in the first byte of an auto header
				if (header_mode == HM_AUTO && ioctl_dout[7:0] != 8'h00) begin
					rom_size <= ioctl_dout[3:0];
					ram_size <= ioctl_dout[7:4];
				end
				case (header_mode)
					HM_NONE,
					HM_LOROM:   rom_type <= 8'd0;
					HM_HIROM:   rom_type <= 8'd1;
					HM_EXHIROM: rom_type <= 8'd2;
					default:    rom_type <= ioctl_dout[15:8];
				endcase
			end

			if (ioctl_addr == dl_addr_t'(2)) begin
				rom_region <= ioctl_dout[8];
			end

			if (forced && ioctl_addr == size_addr) begin
				rom_size <= ioctl_dout[11:8];
			end
			if (forced && ioctl_addr == ram_size_addr) begin
				ram_size <= ioctl_dout[3:0];
			end
		end
	end

	// Masks in units of 1 KB
	assign rom_mask = (MASK_UNIT << rom_size) - mem_mask_t'(1);
	assign ram_mask = (ram_size == '0) ? '0 : (MASK_UNIT << ram_size) - mem_mask_t'(1);

	// Region only settles outside a cartridge download
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			pal <= 1'b0;
		end else if (!cart_active) begin
			pal <= (region_sel == 2'd0) ? rom_region : region_sel[1];
		end
	end

endmodule

// File: rtl/cart_load_ctrl.sv
// Download index decode, write strobe qualification and memory clear sequencing
`timescale 1ns/1ps

module cart_load_ctrl import cart_load_pkg::*; (
	input  logic       clk_sys,
	input  logic       RESET,
	input  logic       ioctl_download,
	input  dl_index_t  ioctl_index,
	input  logic       ioctl_wr,
	output logic       cart_active,
	output logic       hdr_wr,
	output logic       code_wr,
	output logic       sweep_en,
	output fill_addr_t sweep_addr,
	output logic       clearing,
	output logic       cart_busy
);

	logic         cart_active_q;
	logic         cart_start;
	clear_state_t state;

	// ========================================
	// Index decode
	// ========================================
	assign cart_active = ioctl_download & (ioctl_index[5:0] == IDX_CART[5:0]);

	// Write strobes per download type
	assign hdr_wr  = ioctl_wr & cart_active;
	assign code_wr = ioctl_wr & ioctl_download & (ioctl_index == IDX_CHEAT);

	// Start of a cartridge download
	assign cart_start = cart_active & ~cart_active_q;

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			cart_active_q <= 1'b0;
		end else begin
			cart_active_q <= cart_active;
		end
	end

	// ========================================
	// Clear sweep
	// ========================================
	// A new start restarts the sweep from address 0
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			state      <= CLR_IDLE;
			sweep_addr <= '0;
		end else if (cart_start) begin
			state      <= CLR_SWEEP;
			sweep_addr <= '0;
		end else begin
			case (state)
				CLR_IDLE: begin
					sweep_addr <= '0;
				end
				CLR_SWEEP: begin
					// Counter wraps back to 0 after the last address
					sweep_addr <= sweep_addr + fill_addr_t'(1);
					if (sweep_addr == FILL_LAST) begin
						state <= CLR_IDLE;
					end
				end
				default: begin
					state <= CLR_IDLE;
				end
			endcase
		end
	end

	assign clearing = (state == CLR_SWEEP);
	assign sweep_en = clearing;

	// Busy over the whole download and the sweep behind it
	assign cart_busy = cart_active | clearing;

endmodule

// File: common/cart_load_pkg.sv
// Cartridge loader shared types, download index codes and ROM header offsets
package cart_load_pkg;

	// ========================================
	// Vector types
	// ========================================
	typedef logic [7:0]  dl_index_t;
	typedef logic [24:0] dl_addr_t;
	typedef logic [15:0] dl_word_t;
	typedef logic [23:0] mem_mask_t;
	typedef logic [3:0]  mem_size_t;
	typedef logic [7:0]  rom_type_t;
	typedef logic [16:0] fill_addr_t;
	typedef logic [7:0]  fill_byte_t;
	typedef logic [31:0] cheat_word_t;
	typedef logic [2:0]  header_mode_t;

	// Memory clear sequencer
	typedef enum logic {
		CLR_IDLE,
		CLR_SWEEP
	} clear_state_t;

	// ========================================
	// Download index codes
	// ========================================
	// Cartridge index only looks at the low 6 bits
	localparam dl_index_t IDX_CART  = 8'h00;
	localparam dl_index_t IDX_CHEAT = 8'hFF;

	// Forced header modes
	localparam header_mode_t HM_AUTO    = 3'd0;
	localparam header_mode_t HM_NONE    = 3'd1;
	localparam header_mode_t HM_LOROM   = 3'd2;
	localparam header_mode_t HM_HIROM   = 3'd3;
	localparam header_mode_t HM_EXHIROM = 3'd4;

	// ========================================
	// Header layout
	// ========================================
	localparam dl_addr_t COPIER_HDR  = 25'h200;
	localparam dl_addr_t HDR_LO_SIZE = 25'h7FD6 + COPIER_HDR;
	localparam dl_addr_t HDR_HI_SIZE = 25'hFFD6 + COPIER_HDR;
	localparam dl_addr_t HDR_EX_SIZE = 25'h40FFD6 + COPIER_HDR;

	localparam mem_size_t DEFAULT_ROM_SIZE = 4'd12;
	localparam mem_mask_t MASK_UNIT        = 24'd1024;

	// Last address of the clear sweep
	localparam fill_addr_t FILL_LAST = '1;

endpackage
